/* dv/texcache_testdata.txt */
# columns: req x y texel_hex | test name | clear | hold | release | random 0/1 | end
# texel is y<<12 | x inside the 64x48 texture, zero outside
test cold_hit
req 1 2 002001
req 3 3 003003
req 1 2 002001
req 0 0 000000
test conflict
req 17 1 001011
req 2 1 001002
req 18 3 003012
test border
req 64 0 000000
req 10 48 000000
req 1000 5 000000
test credit
hold
req 0 1 001000
req 1 1 001001
req 2 1 001002
req 3 1 001003
req 0 2 002000
req 1 2 002001
release
test clear
clear
req 1 2 002001
test l2_random
random 1
req 40 20 014028
req 44 20 01402c
req 41 21 015029
req 40 36 024028
req 40 20 014028
random 0
end

/* compile.f */
src/texcache_pkg.sv
src/texcache_addr_stage.sv
src/texcache_tag_stage.sv
src/texcache_fill_ctrl.sv
src/texcache_data_stage.sv
src/texcache_l1.sv
dv/texcache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module texcache_tb -f compile.f

out=$(./obj_dir/Vtexcache_tb)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"

/* dv/texcache_tb.sv */
// texture cache testbench
// file-driven requests, L2 block memory model, credit return and in-order response checks
`timescale 1ns/1ps
`default_nettype none

module texcache_tb
	import texcache_pkg::*;
();

	localparam int WIDTH   = 64;
	localparam int HEIGHT  = 48;
	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic rst;
	logic clear_start;
	logic clear_busy;
	coord_t param_width;
	coord_t param_height;
	coord_t s_araddrx;
	coord_t s_araddry;
	logic s_arvalid;
	logic s_arready;
	texel_t s_rdata;
	logic s_rvalid;
	logic r_credit;
	blk_coord_t m_araddrx;
	blk_coord_t m_araddry;
	logic m_arvalid;
	logic m_arready;
	texel_t m_rdata;
	logic m_rvalid;
	logic m_rlast;

	texel_t exp_q[$];
	logic [15:0] exp_blk_q[$];
	int model_tag [LINE_NUM];
	bit model_valid [LINE_NUM];
	int errors = 0;
	int l2_reqs = 0;
	int exp_l2 = 0;
	int owed = 0;
	int hold_pulses = 0;
	bit hold_credit = 1'b0;
	bit rand_ready = 1'b0;
	bit aborted = 1'b0;
	bit got_resp;
	bit withhold;
	bit use_rand;
	logic [31:0] lcg_state = 32'd3350;
	blk_coord_t mem_bx;
	blk_coord_t mem_by;

	always #2 clk = ~clk;

	texcache_l1 i_texcache_l1 (
		.clk(clk), .rst(rst), .clear_start(clear_start), .clear_busy(clear_busy),
		.param_width(param_width), .param_height(param_height),
		.s_araddrx(s_araddrx), .s_araddry(s_araddry), .s_arvalid(s_arvalid),
		.s_arready(s_arready), .s_rdata(s_rdata), .s_rvalid(s_rvalid), .r_credit(r_credit),
		.m_araddrx(m_araddrx), .m_araddry(m_araddry), .m_arvalid(m_arvalid),
		.m_arready(m_arready), .m_rdata(m_rdata), .m_rvalid(m_rvalid), .m_rlast(m_rlast)
	);

	// y in the upper half, x in the lower half, black outside the texture
	function automatic texel_t texel_rule(int x, int y);
		if (x < WIDTH && y < HEIGHT)
			return texel_t'((y << 12) | x);
		return texel_t'(0);
	endfunction

	function automatic texel_t block_texel(blk_coord_t bx, blk_coord_t by, blk_off_t off);
		return {2'b00, by, off[3:2], 2'b00, bx, off[1:0]};
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ------------------------------
	// L2 memory model
	// ------------------------------
	always begin
		@(posedge clk);
		if (!rst && m_arvalid && m_arready) begin
			mem_bx = m_araddrx;
			mem_by = m_araddry;
			l2_reqs++;
			assert (exp_blk_q.size() > 0) else begin
				$display("L2 block request arrived with no miss predicted");
				errors++;
			end
			if (exp_blk_q.size() > 0) begin
				assert (m_araddrx == exp_blk_q[0][7:0]) else begin
					$display("FAIL m_araddrx expected %h got %h", exp_blk_q[0][7:0], m_araddrx);
					errors++;
				end
				assert (m_araddry == exp_blk_q[0][15:8]) else begin
					$display("FAIL m_araddry expected %h got %h", exp_blk_q[0][15:8], m_araddry);
					errors++;
				end
				void'(exp_blk_q.pop_front());
			end
			#1;
			for (int i = 0; i < BLK_PIX; i++) begin
				m_rvalid = 1'b1;
				m_rdata  = block_texel(mem_bx, mem_by, blk_off_t'(i));
				m_rlast  = (i == BLK_PIX - 1);
				@(posedge clk);
				#1;
			end
			m_rvalid = 1'b0;
			m_rlast  = 1'b0;
		end
	end

	always @(posedge clk) begin
		use_rand = rand_ready;
		#1;
		if (use_rand) begin
			lcg_state = lcg_next(lcg_state);
			m_arready = lcg_state[16];
		end else begin
			m_arready = 1'b1;
		end
	end

	// credits go back one per cycle, owed ones later
	always @(posedge clk) begin
		got_resp = !rst && s_rvalid;
		withhold = hold_credit;
		#1;
		if (got_resp)
			owed++;
		if (!withhold && owed > 0) begin
			r_credit = 1'b1;
			owed--;
		end else begin
			r_credit = 1'b0;
		end
	end

	// ------------------------------
	// response scoreboard
	// ------------------------------
	always @(posedge clk) begin
		if (!rst && s_rvalid) begin
			if (hold_credit)
				hold_pulses++;
			assert (exp_q.size() > 0) else begin
				$display("response arrived with no request outstanding");
				errors++;
			end
			if (exp_q.size() > 0) begin
				assert (s_rdata == exp_q[0]) else begin
					$display("FAIL s_rdata expected %h got %h", exp_q[0], s_rdata);
					errors++;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
		aborted = 1'b1;
	endtask

	task automatic issue_req(int x, int y, texel_t exp);
		int cnt;
		int bx;
		int by;
		int line;
		int tag;
		bit accepted;
		assert (exp == texel_rule(x, y)) else begin
			$display("FAIL testdata texel expected %h got %h", texel_rule(x, y), exp);
			errors++;
		end
		exp_q.push_back(texel_rule(x, y));
		if (x < WIDTH && y < HEIGHT) begin
			bx   = x >> 2;
			by   = y >> 2;
			line = ((by & 3) << 2) | (bx & 3);
			tag  = ((by >> 2) << 6) | (bx >> 2);
			if (!model_valid[line] || model_tag[line] != tag) begin
				exp_l2++;
				exp_blk_q.push_back({blk_coord_t'(by), blk_coord_t'(bx)});
			end
			model_valid[line] = 1'b1;
			model_tag[line]   = tag;
		end
		s_araddrx = coord_t'(x);
		s_araddry = coord_t'(y);
		s_arvalid = 1'b1;
		cnt = 0;
		accepted = 1'b0;
		while (!accepted && cnt < TIMEOUT) begin
			@(posedge clk);
			accepted = s_arready;
			#1;
			cnt++;
		end
		s_arvalid = 1'b0;
		if (!accepted)
			timed_out("request handshake");
	endtask

	task automatic drain();
		int cnt;
		cnt = 0;
		while ((exp_q.size() > 0 || m_arvalid || m_rvalid) && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (cnt >= TIMEOUT)
			timed_out("outstanding responses");
	endtask

	task automatic do_clear();
		int cnt;
		drain();
		clear_start = 1'b1;
		@(posedge clk);
		#1;
		clear_start = 1'b0;
		cnt = 0;
		while (!clear_busy && cnt < 100) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (cnt >= 100)
			timed_out("clear to start");
		cnt = 0;
		while (clear_busy && cnt < 100) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (cnt >= 100)
			timed_out("clear to finish");
		for (int i = 0; i < LINE_NUM; i++)
			model_valid[i] = 1'b0;
	endtask

	initial begin
		int fd;
		int code;
		int x;
		int y;
		int n;
		int tests;
		int passed;
		int errs_at_start;
		bit have_test;
		string tok;
		string name;
		texel_t exp;
		logic [8*128-1:0] linebuf;

		rst = 1'b1;
		clear_start = 1'b0;
		param_width = coord_t'(WIDTH);
		param_height = coord_t'(HEIGHT);
		s_araddrx = '0;
		s_araddry = '0;
		s_arvalid = 1'b0;
		r_credit = 1'b0;
		m_arready = 1'b1;
		m_rdata = '0;
		m_rvalid = 1'b0;
		m_rlast = 1'b0;
		tests = 0;
		passed = 0;
		errs_at_start = 0;
		have_test = 1'b0;
		for (int i = 0; i < LINE_NUM; i++)
			model_valid[i] = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		fd = $fopen("dv/texcache_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			errors++;
			aborted = 1'b1;
		end
		while (!aborted) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				break;
			if (tok == "#") begin
				void'($fgets(linebuf, fd));
			end else if (tok == "test" || tok == "end") begin
				if (have_test) begin
					drain();
					assert (l2_reqs == exp_l2) else begin
						$display("FAIL l2_reqs expected %h got %h", exp_l2, l2_reqs);
						errors++;
					end
					tests++;
					if (errors == errs_at_start)
						passed++;
					$display("test %s: %0d errors", name, errors - errs_at_start);
				end
				if (tok == "test")
					code = $fscanf(fd, "%s", name);
				have_test = (tok == "test");
				errs_at_start = errors;
			end else if (tok == "req") begin
				code = $fscanf(fd, "%d %d %h", x, y, exp);
				issue_req(x, y, exp);
			end else if (tok == "clear") begin
				do_clear();
			end else if (tok == "hold") begin
				hold_pulses = 0;
				hold_credit = 1'b1;
			end else if (tok == "release") begin
				// let the pipeline freeze before counting
				repeat (30) @(posedge clk);
				#1;
				assert (hold_pulses <= CREDIT_MAX) else begin
					$display("more responses than credits while credits were held");
					errors++;
				end
				hold_credit = 1'b0;
			end else if (tok == "random") begin
				code = $fscanf(fd, "%d", n);
				rand_ready = (n != 0);
			end else begin
				$display("unknown keyword %s in test data", tok);
				errors++;
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests run %0d, passed %0d, errors %0d", tests, passed, errors);
		if (errors == 0 && !aborted) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/texcache_l1.sv */
// texture L1 cache top
// address, tag and data stages with the L2 fill controller and the shared pipeline stall
`timescale 1ns/1ps
`default_nettype none

module texcache_l1
	import texcache_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       clear_start,
	output logic       clear_busy,
	input  coord_t     param_width,
	input  coord_t     param_height,
	input  coord_t     s_araddrx,
	input  coord_t     s_araddry,
	input  logic       s_arvalid,
	output logic       s_arready,
	output texel_t     s_rdata,
	output logic       s_rvalid,
	input  logic       r_credit,
	output blk_coord_t m_araddrx,
	output blk_coord_t m_araddry,
	output logic       m_arvalid,
	input  logic       m_arready,
	input  texel_t     m_rdata,
	input  logic       m_rvalid,
	input  logic       m_rlast
);

	logic      stall;
	logic      miss_stall;
	logic      credit_stall;
	logic      addr_valid;
	lookup_t   addr_lookup;
	logic      tag_valid;
	lookup_t   tag_lookup;
	logic      fill_valid;
	fill_req_t fill_req;
	logic      fill_done;
	logic      fill_we;
	ram_addr_t fill_addr;
	texel_t    fill_data;

	// one stall freezes every stage register
	assign stall = miss_stall | credit_stall;

	texcache_addr_stage i_addr_stage (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.param_width  (param_width),
		.param_height (param_height),
		.s_araddrx    (s_araddrx),
		.s_araddry    (s_araddry),
		.s_arvalid    (s_arvalid),
		.s_arready    (s_arready),
		.clear_busy   (clear_busy),
		.out_valid    (addr_valid),
		.out_lookup   (addr_lookup)
	);

	texcache_tag_stage i_tag_stage (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (addr_valid),
		.in_lookup   (addr_lookup),
		.clear_start (clear_start),
		.clear_busy  (clear_busy),
		.miss_stall  (miss_stall),
		.fill_valid  (fill_valid),
		.fill_req    (fill_req),
		.fill_done   (fill_done),
		.stall       (stall),
		.out_valid   (tag_valid),
		.out_lookup  (tag_lookup)
	);

	texcache_fill_ctrl i_fill_ctrl (
		.clk        (clk),
		.rst        (rst),
		.fill_valid (fill_valid),
		.fill_req   (fill_req),
		.fill_done  (fill_done),
		.fill_we    (fill_we),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.m_araddrx  (m_araddrx),
		.m_araddry  (m_araddry),
		.m_arvalid  (m_arvalid),
		.m_arready  (m_arready),
		.m_rdata    (m_rdata),
		.m_rvalid   (m_rvalid),
		.m_rlast    (m_rlast)
	);

	texcache_data_stage i_data_stage (
		.clk          (clk),
		.rst          (rst),
		.stall        (stall),
		.in_valid     (tag_valid),
		.in_lookup    (tag_lookup),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.s_rdata      (s_rdata),
		.s_rvalid     (s_rvalid),
		.r_credit     (r_credit),
		.credit_stall (credit_stall)
	);

endmodule

`default_nettype wire

/* src/texcache_data_stage.sv */
// texture cache data stage
// texel RAM read or border substitution, response out under credit control
`timescale 1ns/1ps
`default_nettype none

module texcache_data_stage
	import texcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      stall,
	input  logic      in_valid,
	input  lookup_t   in_lookup,
	input  logic      fill_we,
	input  ram_addr_t fill_addr,
	input  texel_t    fill_data,
	output texel_t    s_rdata,
	output logic      s_rvalid,
	input  logic      r_credit,
	output logic      credit_stall
);

	texel_t    mem [LINE_NUM*BLK_PIX];
	ram_addr_t rd_addr;
	logic      d_valid;
	texel_t    d_data;
	credit_t   credit;
	logic      has_credit;

	assign rd_addr = {in_lookup.line, in_lookup.off};

	always_ff @(posedge clk) begin
		if (fill_we)
			mem[fill_addr] <= fill_data;
	end

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!stall && in_valid)
			d_data <= in_lookup.border ? BORDER_TEXEL : mem[rd_addr];
	end

	// a texel sent during a miss stall empties the register
	always_ff @(posedge clk) begin
		if (rst)
			d_valid <= 1'b0;
		else if (!stall)
			d_valid <= in_valid;
		else if (s_rvalid)
			d_valid <= 1'b0;
	end

	assign has_credit   = (credit != '0);
	assign s_rvalid     = d_valid & has_credit;
	assign credit_stall = d_valid & ~has_credit;
	assign s_rdata      = d_data;

	// ------------------------------
	// credit counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			credit <= credit_t'(CREDIT_MAX);
		else
			credit <= credit + credit_t'(r_credit) - credit_t'(s_rvalid);
	end

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credit <= credit_t'(CREDIT_MAX));

endmodule

`default_nettype wire

/* src/texcache_fill_ctrl.sv */
// texture cache fill controller
// fetches one 4x4 block from L2 per miss and writes the beats into the data RAM
`timescale 1ns/1ps
`default_nettype none

module texcache_fill_ctrl
	import texcache_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       fill_valid,
	input  fill_req_t  fill_req,
	output logic       fill_done,
	output logic       fill_we,
	output ram_addr_t  fill_addr,
	output texel_t     fill_data,
	output blk_coord_t m_araddrx,
	output blk_coord_t m_araddry,
	output logic       m_arvalid,
	input  logic       m_arready,
	input  texel_t     m_rdata,
	input  logic       m_rvalid,
	input  logic       m_rlast
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RECV,
		ST_DONE
	} fill_state_t;

	fill_state_t state;
	fill_req_t   req_q;
	blk_off_t    beat_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
			ST_IDLE: begin
				beat_cnt <= '0;
				if (fill_valid)
					state <= ST_REQ;
			end
			ST_REQ: begin
				if (m_arready)
					state <= ST_RECV;
			end
			ST_RECV: begin
				if (m_rvalid) begin
					beat_cnt <= beat_cnt + 1'b1;
					if (m_rlast)
						state <= ST_DONE;
				end
			end
			// tag stage commits the line here
			ST_DONE: state <= ST_IDLE;
			default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && fill_valid)
			req_q <= fill_req;
	end

	// ------------------------------
	// L2 request and RAM write
	// ------------------------------
	assign m_arvalid = (state == ST_REQ);
	assign m_araddrx = req_q.blk_x;
	assign m_araddry = req_q.blk_y;

	// beats come in raster order, so the count is the offset
	assign fill_we        = (state == ST_RECV) & m_rvalid;
	assign fill_addr.line = req_q.line;
	assign fill_addr.off  = beat_cnt;
	assign fill_data      = m_rdata;
	assign fill_done      = (state == ST_DONE);

	a_rlast_beat: assert property (@(posedge clk) disable iff (rst)
		(state == ST_RECV && m_rvalid) |-> (m_rlast == (beat_cnt == blk_off_t'(BLK_PIX - 1))));

endmodule

`default_nettype wire

/* src/texcache_tag_stage.sv */
// texture cache tag stage
// direct mapped tag lookup, miss hand-off to the fill controller and the clear sweep
`timescale 1ns/1ps
`default_nettype none

module texcache_tag_stage
	import texcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	input  lookup_t   in_lookup,
	input  logic      clear_start,
	output logic      clear_busy,
	output logic      miss_stall,
	output logic      fill_valid,
	output fill_req_t fill_req,
	input  logic      fill_done,
	input  logic      stall,
	output logic      out_valid,
	output lookup_t   out_lookup
);

	typedef enum logic {
		CLR_IDLE,
		CLR_SWEEP
	} clr_state_t;

	clr_state_t          clr_state;
	line_idx_t           sweep_idx;
	logic                clear_pend;
	logic [LINE_NUM-1:0] line_valid;
	tag_t                tag_ram [LINE_NUM];

	logic    t_valid;
	lookup_t t_lookup;
	logic    adv;
	logic    hit;
	logic    miss;
	logic    pipe_empty;

	assign clear_busy = (clr_state == CLR_SWEEP);
	assign adv        = ~stall & ~clear_busy;
	assign pipe_empty = ~in_valid & ~t_valid;

	// ------------------------------
	// lookup
	// ------------------------------
	assign hit  = line_valid[t_lookup.line] & (tag_ram[t_lookup.line] == t_lookup.tag);
	assign miss = t_valid & ~t_lookup.border & ~hit;

	assign miss_stall = miss;
	assign fill_valid = miss;

	// block coordinate rebuilt from tag and line
	assign fill_req.blk_x = {t_lookup.tag[5:0], t_lookup.line[1:0]};
	assign fill_req.blk_y = {t_lookup.tag[11:6], t_lookup.line[3:2]};
	assign fill_req.line  = t_lookup.line;

	assign out_valid  = t_valid & ~miss;
	assign out_lookup = t_lookup;

	always_ff @(posedge clk) begin
		if (rst)
			t_valid <= 1'b0;
		else if (adv)
			t_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (adv)
			t_lookup <= in_lookup;
	end

	always_ff @(posedge clk) begin
		if (fill_done)
			tag_ram[t_lookup.line] <= t_lookup.tag;
	end

	// ------------------------------
	// valid bits and clear sweep
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			clr_state  <= CLR_IDLE;
			clear_pend <= 1'b0;
			sweep_idx  <= '0;
			line_valid <= '0;
		end else begin
			if (fill_done)
				line_valid[t_lookup.line] <= 1'b1;
			case (clr_state)
			CLR_IDLE: begin
				// wait for in-flight lookups to drain
				if ((clear_pend | clear_start) && pipe_empty) begin
					clr_state  <= CLR_SWEEP;
					clear_pend <= 1'b0;
					sweep_idx  <= '0;
				end else begin
					clear_pend <= clear_pend | clear_start;
				end
			end
			CLR_SWEEP: begin
				line_valid[sweep_idx] <= 1'b0;
				sweep_idx <= sweep_idx + 1'b1;
				if (sweep_idx == line_idx_t'(LINE_NUM - 1))
					clr_state <= CLR_IDLE;
			end
			default: clr_state <= CLR_IDLE;
			endcase
		end
	end

	a_done_in_fill: assert property (@(posedge clk) disable iff (rst)
		fill_done |-> fill_valid);

	a_no_fill_in_clear: assert property (@(posedge clk) disable iff (rst)
		!(clear_busy && fill_valid));

endmodule

`default_nettype wire

/* src/texcache_addr_stage.sv */
// texture cache address stage
// takes the texel request, flags border coordinates and splits the rest into tag, line, offset
`timescale 1ns/1ps
`default_nettype none

module texcache_addr_stage
	import texcache_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  coord_t  param_width,
	input  coord_t  param_height,
	input  coord_t  s_araddrx,
	input  coord_t  s_araddry,
	input  logic    s_arvalid,
	output logic    s_arready,
	input  logic    clear_busy,
	output logic    out_valid,
	output lookup_t out_lookup
);

	logic       run_q;
	logic       hold;
	logic       accept;
	blk_coord_t blk_x;
	blk_coord_t blk_y;
	lookup_t    split;

	// stage holds on stall and during the tag sweep
	assign hold      = stall | clear_busy;
	assign s_arready = run_q & ~hold;
	assign accept    = s_arvalid & s_arready;

	assign blk_x = blk_coord_t'(s_araddrx >> BLK_X_SIZE);
	assign blk_y = blk_coord_t'(s_araddry >> BLK_Y_SIZE);

	// line from the low block bits, tag from the rest
	always_comb begin
		split.tag    = {blk_y[7:2], blk_x[7:2]};
		split.line   = {blk_y[1:0], blk_x[1:0]};
		split.off    = {s_araddry[BLK_Y_SIZE-1:0], s_araddrx[BLK_X_SIZE-1:0]};
		split.border = (s_araddrx >= param_width) | (s_araddry >= param_height);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			run_q     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (!hold)
				out_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			out_lookup <= split;
	end

	a_hold_stable: assert property (@(posedge clk) disable iff (rst)
		(stall && out_valid) |=> $stable(out_lookup));

endmodule

`default_nettype wire

/* src/texcache_pkg.sv */
// texture cache shared definitions
// field widths, cache geometry and the structs passed between stages
`default_nettype none

package texcache_pkg;

	// ------------------------------
	// cache geometry
	// ------------------------------
	localparam int BLK_X_SIZE = 2;
	localparam int BLK_Y_SIZE = 2;
	localparam int BLK_PIX    = 1 << (BLK_X_SIZE + BLK_Y_SIZE);
	localparam int LINE_NUM   = 16;
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

	// ------------------------------
	// field types
	// ------------------------------
	typedef logic [9:0]          coord_t;
	typedef logic [23:0]         texel_t;
	typedef logic [7:0]          blk_coord_t;
	typedef logic [3:0]          line_idx_t;
	typedef logic [11:0]         tag_t;
	typedef logic [3:0]          blk_off_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	// out of range texels read as black
	localparam texel_t BORDER_TEXEL = '0;

	// one request on its way down the pipe
	typedef struct packed {
		tag_t      tag;
		line_idx_t line;
		blk_off_t  off;
		logic      border;
	} lookup_t;

	// block to fetch from L2
	typedef struct packed {
		blk_coord_t blk_x;
		blk_coord_t blk_y;
		line_idx_t  line;
	} fill_req_t;

	// data RAM word address
	typedef struct packed {
		line_idx_t line;
		blk_off_t  off;
	} ram_addr_t;

endpackage

`default_nettype wire
